/* source/intr_pkg.sv */
package intr_pkg;

   // Bus widths
   localparam int data_width     = 32;
   localparam int apb_addr_width = 8;

   // Line counts toward host and user
   localparam int c2h_intr_width = 64;    // Two words
   localparam int h2c_intr_width = 128;   // Four words
   localparam int gpio_width     = 256;   // Eight words each way
   localparam int pulse_width    = 64;

   // Byte offset of the first word in each register group
   localparam logic [apb_addr_width-1:0] addr_h2c_intr      = 8'h00;
   localparam logic [apb_addr_width-1:0] addr_h2c_gpio      = 8'h10;
   localparam logic [apb_addr_width-1:0] addr_h2c_pulse     = 8'h30;
   localparam logic [apb_addr_width-1:0] addr_c2h_status    = 8'h38;   // Read only
   localparam logic [apb_addr_width-1:0] addr_toggle_status = 8'h40;   // Read only
   localparam logic [apb_addr_width-1:0] addr_toggle_enable = 8'h48;
   localparam logic [apb_addr_width-1:0] addr_toggle_clear  = 8'h50;   // Write only
   localparam logic [apb_addr_width-1:0] addr_c2h_gpio      = 8'h58;   // Read only

   // First byte past the map
   localparam logic [apb_addr_width-1:0] addr_map_end       = 8'h78;

endpackage

/* source/apb_reg_file.sv */
`timescale 1ns/100ps

module apb_reg_file
   import intr_pkg::*;
(
   input  logic                      axi_aclk,
   input  logic                      axi_aresetn,
   input  logic                      psel,
   input  logic                      penable,
   input  logic                      pwrite,
   input  logic [apb_addr_width-1:0] paddr,
   input  logic [data_width-1:0]     pwdata,
   output logic [data_width-1:0]     prdata,
   output logic                      pready,
   output logic                      pslverr,
   input  logic [c2h_intr_width-1:0] c2h_status,
   input  logic [c2h_intr_width-1:0] toggle_status,
   input  logic [gpio_width-1:0]     c2h_gpio_status,
   output logic [h2c_intr_width-1:0] h2c_intr_regs,
   output logic [gpio_width-1:0]     h2c_gpio_regs,
   output logic [pulse_width-1:0]    h2c_pulse_regs,
   output logic [c2h_intr_width-1:0] toggle_enable,
   output logic [c2h_intr_width-1:0] toggle_clear
);

   // Register group codes
   localparam logic [2:0] grp_intr   = 3'd0;
   localparam logic [2:0] grp_gpio   = 3'd1;
   localparam logic [2:0] grp_pulse  = 3'd2;
   localparam logic [2:0] grp_status = 3'd3;
   localparam logic [2:0] grp_toggle = 3'd4;
   localparam logic [2:0] grp_enable = 3'd5;
   localparam logic [2:0] grp_clear  = 3'd6;
   localparam logic [2:0] grp_cgpio  = 3'd7;

   logic                      access;     // APB access phase
   logic                      wr_en;
   logic                      mapped;
   logic [2:0]                grp;
   logic [apb_addr_width-1:0] base;       // First byte of the selected group
   logic [apb_addr_width-1:0] offset;
   logic [apb_addr_width-3:0] word_idx;   // Word within the group
   logic [data_width-1:0]     rd_data;

   assign access   = psel & penable;
   assign wr_en    = access & pwrite & mapped;
   assign offset   = paddr - base;
   assign word_idx = offset[apb_addr_width-1:2];

   // Group decode, groups are contiguous in address order
   always_comb
   begin
      mapped = 1'b1;
      if (paddr < addr_h2c_gpio)
      begin
         grp  = grp_intr;
         base = addr_h2c_intr;
      end
      else if (paddr < addr_h2c_pulse)
      begin
         grp  = grp_gpio;
         base = addr_h2c_gpio;
      end
      else if (paddr < addr_c2h_status)
      begin
         grp  = grp_pulse;
         base = addr_h2c_pulse;
      end
      else if (paddr < addr_toggle_status)
      begin
         grp  = grp_status;
         base = addr_c2h_status;
      end
      else if (paddr < addr_toggle_enable)
      begin
         grp  = grp_toggle;
         base = addr_toggle_status;
      end
      else if (paddr < addr_toggle_clear)
      begin
         grp  = grp_enable;
         base = addr_toggle_enable;
      end
      else if (paddr < addr_c2h_gpio)
      begin
         grp  = grp_clear;
         base = addr_toggle_clear;
      end
      else
      begin
         grp    = grp_cgpio;
         base   = addr_c2h_gpio;
         mapped = (paddr < addr_map_end);   // Tail of the space is a hole
      end
   end

   // Read-back mux
   always_comb
   begin
      case (grp)
         grp_intr:   rd_data = h2c_intr_regs[word_idx*data_width +: data_width];
         grp_gpio:   rd_data = h2c_gpio_regs[word_idx*data_width +: data_width];
         grp_pulse:  rd_data = h2c_pulse_regs[word_idx*data_width +: data_width];
         grp_status: rd_data = c2h_status[word_idx*data_width +: data_width];
         grp_toggle: rd_data = toggle_status[word_idx*data_width +: data_width];
         grp_enable: rd_data = toggle_enable[word_idx*data_width +: data_width];
         grp_cgpio:  rd_data = c2h_gpio_status[word_idx*data_width +: data_width];
         default:    rd_data = '0;          // Clear words read zero
      endcase
   end

   assign prdata  = mapped ? rd_data : '0;
   assign pready  = access;                 // No wait states
   assign pslverr = access & ~mapped;

   // Host-written registers, updated at the end of the access cycle
   always_ff @(posedge axi_aclk)
   begin
      if (!axi_aresetn)
      begin
         h2c_intr_regs  <= '0;
         h2c_gpio_regs  <= '0;
         h2c_pulse_regs <= '0;
         toggle_enable  <= '0;
      end
      else if (wr_en)
      begin
         case (grp)
            grp_intr:   h2c_intr_regs[word_idx*data_width +: data_width] <= pwdata;
            grp_gpio:   h2c_gpio_regs[word_idx*data_width +: data_width] <= pwdata;
            grp_pulse:  h2c_pulse_regs[word_idx*data_width +: data_width] <= pwdata;
            grp_enable: toggle_enable[word_idx*data_width +: data_width] <= pwdata;
            default:    ;                   // Read-only and clear words hold nothing
         endcase
      end
   end

   // Clear strobe lives only in the write access cycle
   always_comb
   begin
      toggle_clear = '0;
      if (wr_en && (grp == grp_clear))
         toggle_clear[word_idx*data_width +: data_width] = pwdata;
   end

endmodule

/* source/c2h_input_capture.sv */
`timescale 1ns/100ps

module c2h_input_capture
   import intr_pkg::*;
(
   input  logic                      axi_aclk,
   input  logic                      axi_aresetn,
   input  logic [c2h_intr_width-1:0] c2h_intr_in,
   input  logic [gpio_width-1:0]     c2h_gpio_in,
   input  logic [c2h_intr_width-1:0] toggle_clear,
   output logic [c2h_intr_width-1:0] c2h_status,
   output logic [c2h_intr_width-1:0] toggle_status,
   output logic [gpio_width-1:0]     c2h_gpio_status
);

   logic [c2h_intr_width-1:0] intr_rise;
   logic [c2h_intr_width-1:0] intr_fall;
   logic [c2h_intr_width-1:0] intr_edge;
   logic [c2h_intr_width-1:0] toggle_next;

   // Level status is also the previous sample for edge detection
   assign intr_rise = c2h_intr_in & ~c2h_status;
   assign intr_fall = ~c2h_intr_in & c2h_status;
   assign intr_edge = intr_rise | intr_fall;

   // Sticky toggle bits
   always_comb
   begin
      for (int i = 0; i < c2h_intr_width; i++)
      begin
         if (toggle_status[i])
            toggle_next[i] = ~toggle_clear[i];   // Held until cleared
         else
            toggle_next[i] = intr_edge[i];       // Any edge sets
      end
   end

   always_ff @(posedge axi_aclk)
   begin
      if (!axi_aresetn)
      begin
         c2h_status    <= '0;
         toggle_status <= '0;
      end
      else
      begin
         c2h_status    <= c2h_intr_in;
         toggle_status <= toggle_next;
      end
   end

   // User GPIO sampled every cycle
   always_ff @(posedge axi_aclk)
   begin
      if (!axi_aresetn)
         c2h_gpio_status <= '0;
      else
         c2h_gpio_status <= c2h_gpio_in;
   end

endmodule

/* source/irq_controller.sv */
`timescale 1ns/100ps

module irq_controller
   import intr_pkg::*;
(
   input  logic                      axi_aclk,
   input  logic                      axi_aresetn,
   input  logic [c2h_intr_width-1:0] toggle_status,
   input  logic [c2h_intr_width-1:0] toggle_enable,
   input  logic                      irq_ack,
   output logic                      irq_out
);

   // Handshake states
   localparam logic [1:0] st_idle     = 2'b00;
   localparam logic [1:0] st_assert   = 2'b01;
   localparam logic [1:0] st_acked    = 2'b10;
   localparam logic [1:0] st_deassert = 2'b11;

   logic [1:0] state;
   logic [1:0] next_state;
   logic       pending;

   // Any enabled toggle still set
   assign pending = |(toggle_status & toggle_enable);

   always_ff @(posedge axi_aclk)
   begin
      if (!axi_aresetn)
         state <= st_idle;
      else
         state <= next_state;
   end

   always_comb
   begin
      next_state = state;
      case (state)
         st_idle:
            if (pending)
               next_state = st_assert;
         st_assert:
            if (irq_ack)
               next_state = st_acked;
         st_acked:
            if (!pending)
               next_state = st_deassert;   // Host has cleared everything
         st_deassert:
            if (irq_ack)
               next_state = st_idle;
         default:
            next_state = st_idle;
      endcase
   end

   // High from request until pending is gone
   assign irq_out = (state == st_assert) || (state == st_acked);

endmodule

/* source/h2c_signal_gen.sv */
`timescale 1ns/100ps

module h2c_signal_gen
   import intr_pkg::*;
(
   input  logic                      axi_aclk,
   input  logic                      axi_aresetn,
   input  logic [h2c_intr_width-1:0] h2c_intr_regs,
   input  logic [gpio_width-1:0]     h2c_gpio_regs,
   input  logic [pulse_width-1:0]    h2c_pulse_regs,
   output logic [h2c_intr_width-1:0] h2c_intr_out,
   output logic [gpio_width-1:0]     h2c_gpio_out,
   output logic [pulse_width-1:0]    h2c_pulse_out
);

   logic [pulse_width-1:0] pulse_prev;   // Pulse register one cycle back

   // GPIO goes straight out
   assign h2c_gpio_out = h2c_gpio_regs;

   // One cycle for each bit that just rose
   assign h2c_pulse_out = h2c_pulse_regs & ~pulse_prev;

   always_ff @(posedge axi_aclk)
   begin
      if (!axi_aresetn)
      begin
         h2c_intr_out <= '0;
         pulse_prev   <= '0;
      end
      else
      begin
         h2c_intr_out <= h2c_intr_regs;
         pulse_prev   <= h2c_pulse_regs;
      end
   end

endmodule

/* source/intr_handler_top.sv */
`timescale 1ns/100ps

module intr_handler_top
   import intr_pkg::*;
(
   input  logic                      axi_aclk,
   input  logic                      axi_aresetn,
   // APB slave
   input  logic                      psel,
   input  logic                      penable,
   input  logic                      pwrite,
   input  logic [apb_addr_width-1:0] paddr,
   input  logic [data_width-1:0]     pwdata,
   output logic [data_width-1:0]     prdata,
   output logic                      pready,
   output logic                      pslverr,
   // Host side
   output logic                      irq_out,
   input  logic                      irq_ack,
   // User side
   input  logic [c2h_intr_width-1:0] c2h_intr_in,
   input  logic [gpio_width-1:0]     c2h_gpio_in,
   output logic [h2c_intr_width-1:0] h2c_intr_out,
   output logic [gpio_width-1:0]     h2c_gpio_out,
   output logic [pulse_width-1:0]    h2c_pulse_out
);

   logic [h2c_intr_width-1:0] h2c_intr_regs;
   logic [gpio_width-1:0]     h2c_gpio_regs;
   logic [pulse_width-1:0]    h2c_pulse_regs;
   logic [c2h_intr_width-1:0] toggle_enable;
   logic [c2h_intr_width-1:0] toggle_clear;     // Strobe in the write cycle
   logic [c2h_intr_width-1:0] c2h_status;
   logic [c2h_intr_width-1:0] toggle_status;
   logic [gpio_width-1:0]     c2h_gpio_status;

   apb_reg_file u_apb_reg_file (
      .axi_aclk        (axi_aclk),
      .axi_aresetn     (axi_aresetn),
      .psel            (psel),
      .penable         (penable),
      .pwrite          (pwrite),
      .paddr           (paddr),
      .pwdata          (pwdata),
      .prdata          (prdata),
      .pready          (pready),
      .pslverr         (pslverr),
      .c2h_status      (c2h_status),
      .toggle_status   (toggle_status),
      .c2h_gpio_status (c2h_gpio_status),
      .h2c_intr_regs   (h2c_intr_regs),
      .h2c_gpio_regs   (h2c_gpio_regs),
      .h2c_pulse_regs  (h2c_pulse_regs),
      .toggle_enable   (toggle_enable),
      .toggle_clear    (toggle_clear)
   );

   c2h_input_capture u_c2h_input_capture (
      .axi_aclk        (axi_aclk),
      .axi_aresetn     (axi_aresetn),
      .c2h_intr_in     (c2h_intr_in),
      .c2h_gpio_in     (c2h_gpio_in),
      .toggle_clear    (toggle_clear),
      .c2h_status      (c2h_status),
      .toggle_status   (toggle_status),
      .c2h_gpio_status (c2h_gpio_status)
   );

   irq_controller u_irq_controller (
      .axi_aclk      (axi_aclk),
      .axi_aresetn   (axi_aresetn),
      .toggle_status (toggle_status),
      .toggle_enable (toggle_enable),
      .irq_ack       (irq_ack),
      .irq_out       (irq_out)
   );

   h2c_signal_gen u_h2c_signal_gen (
      .axi_aclk       (axi_aclk),
      .axi_aresetn    (axi_aresetn),
      .h2c_intr_regs  (h2c_intr_regs),
      .h2c_gpio_regs  (h2c_gpio_regs),
      .h2c_pulse_regs (h2c_pulse_regs),
      .h2c_intr_out   (h2c_intr_out),
      .h2c_gpio_out   (h2c_gpio_out),
      .h2c_pulse_out  (h2c_pulse_out)
   );

endmodule

/* verification/intr_handler_assert.sv */
`timescale 1ns/100ps

module intr_handler_assert
(
   input logic       axi_aclk,
   input logic       axi_aresetn,
   input logic [1:0] state,
   input logic       pending,
   input logic       irq_out
);

   // Reset forces the request low at the next edge
   reset_low: assert property (@(posedge axi_aclk) !axi_aresetn |=> !irq_out)
      else $error("irq_out not low in reset");

   state_known: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
      !$isunknown(state))
      else $error("irq_controller state is not a legal value");

   // Acked request holds until the host clears everything
   hold_acked: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
      (state == 2'b10 && pending) |=> irq_out)
      else $error("irq_out fell in acked state with pending set");

endmodule

bind irq_controller intr_handler_assert u_irq_assert (
   .axi_aclk    (axi_aclk),
   .axi_aresetn (axi_aresetn),
   .state       (state),
   .pending     (pending),
   .irq_out     (irq_out)
);

/* verification/tb_intr_handler.sv */
`timescale 1ns/100ps

module tb_intr_handler
   import intr_pkg::*;
();

   localparam int timeout_cycles = 50;
   localparam int table_size     = 24;

   logic                      axi_aclk;
   logic                      axi_aresetn;
   logic                      psel;
   logic                      penable;
   logic                      pwrite;
   logic [apb_addr_width-1:0] paddr;
   logic [data_width-1:0]     pwdata;
   logic [data_width-1:0]     prdata;
   logic                      pready;
   logic                      pslverr;
   logic                      irq_out;
   logic                      irq_ack;
   logic [c2h_intr_width-1:0] c2h_intr_in;
   logic [gpio_width-1:0]     c2h_gpio_in;
   logic [h2c_intr_width-1:0] h2c_intr_out;
   logic [gpio_width-1:0]     h2c_gpio_out;
   logic [pulse_width-1:0]    h2c_pulse_out;

   logic [31:0] seed = 32'hd7e3;
   int          errors;
   int          tests;
   int          failed_tests;
   int          errors_at_start;

   // Stimulus table
   string                     tbl_name  [table_size];
   logic [apb_addr_width-1:0] tbl_addr  [table_size];
   logic [data_width-1:0]     tbl_wdata [table_size];
   logic [data_width-1:0]     tbl_exp   [table_size];
   logic                      tbl_err   [table_size];
   int                        tbl_count;

   // Reference state
   logic [h2c_intr_width-1:0] intr_model;
   logic [gpio_width-1:0]     gpio_model;
   logic [pulse_width-1:0]    pulse_model;
   logic [c2h_intr_width-1:0] level_model;
   logic [c2h_intr_width-1:0] toggle_model;
   logic [c2h_intr_width-1:0] next_in;
   logic [data_width-1:0]     rd;
   logic [data_width-1:0]     pat;
   logic                      err;

   intr_handler_top uut (.*);

   initial
   begin
      axi_aclk = 1'b0;
      forever #10 axi_aclk = ~axi_aclk;
   end

   function automatic logic [31:0] lcg_next();
      seed = seed * 32'd1664525 + 32'd1013904223;
      return seed;
   endfunction

   task check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
      if (exp !== act)
      begin
         errors++;
         $display("ERR %s expected %h actual %h", name, exp, act);
      end
   endtask

   task finish_test(input string name);
      tests++;
      if (errors != errors_at_start)
      begin
         failed_tests++;
         $display("FAIL %s", name);
      end
      else
         $display("PASS %s", name);
      errors_at_start = errors;
   endtask

   // Setup then access phase, result sampled at the falling edge
   task apb_transfer(input logic wr, input logic [apb_addr_width-1:0] addr,
                     input logic [31:0] wdata, output logic [31:0] rdata, output logic slverr);
      int n;
      n = 0;
      @(posedge axi_aclk);
      psel    <= 1'b1;
      penable <= 1'b0;
      pwrite  <= wr;
      paddr   <= addr;
      pwdata  <= wdata;
      @(posedge axi_aclk);
      penable <= 1'b1;
      @(negedge axi_aclk);
      while (!pready && n < timeout_cycles)
      begin
         @(negedge axi_aclk);
         n++;
      end
      if (!pready)
      begin
         errors++;
         $display("APB access to address %h never saw pready", addr);
      end
      rdata  = prdata;
      slverr = pslverr;
      @(posedge axi_aclk);
      psel    <= 1'b0;
      penable <= 1'b0;
      pwrite  <= 1'b0;
   endtask

   task apb_write(input logic [apb_addr_width-1:0] addr, input logic [31:0] data,
                  output logic slverr);
      logic [31:0] unused;
      apb_transfer(1'b1, addr, data, unused, slverr);
   endtask

   task apb_read(input logic [apb_addr_width-1:0] addr, output logic [31:0] data,
                 output logic slverr);
      apb_transfer(1'b0, addr, 32'd0, data, slverr);
   endtask

   task add_entry(input string name, input logic [apb_addr_width-1:0] addr,
                  input logic [31:0] wdata, input logic [31:0] exp, input logic slverr);
      tbl_name[tbl_count]  = name;
      tbl_addr[tbl_count]  = addr;
      tbl_wdata[tbl_count] = wdata;
      tbl_exp[tbl_count]   = exp;
      tbl_err[tbl_count]   = slverr;
      tbl_count++;
   endtask

   task fill_table();
      logic [31:0] d;
      tbl_count = 0;
      for (int w = 0; w < 4; w++)
      begin
         d = lcg_next();
         intr_model[w*32 +: 32] = d;
         add_entry($sformatf("h2c_intr word %0d", w), addr_h2c_intr + 8'(w*4), d, d, 1'b0);
      end
      for (int w = 0; w < 8; w++)
      begin
         d = lcg_next();
         gpio_model[w*32 +: 32] = d;
         add_entry($sformatf("h2c_gpio word %0d", w), addr_h2c_gpio + 8'(w*4), d, d, 1'b0);
      end
      for (int w = 0; w < 2; w++)
      begin
         d = lcg_next();
         add_entry($sformatf("enable word %0d", w), addr_toggle_enable + 8'(w*4), d, d, 1'b0);
         add_entry($sformatf("clear word %0d", w), addr_toggle_clear + 8'(w*4),
                   lcg_next(), 32'd0, 1'b0);
      end
      add_entry("c2h_status read only", addr_c2h_status, lcg_next(), 32'd0, 1'b0);
      add_entry("unmapped 0x78", 8'h78, lcg_next(), 32'd0, 1'b1);
      add_entry("unmapped 0xfc", 8'hfc, lcg_next(), 32'd0, 1'b1);
   endtask

   // Counts pulse cycles per bit after one register write
   task pulse_step(input string name, input int word, input logic [31:0] value);
      logic                   slverr;
      logic [pulse_width-1:0] expected;
      logic [pulse_width-1:0] seen_once;
      logic [pulse_width-1:0] seen_more;
      int                     cnt [pulse_width];
      expected = '0;
      expected[word*32 +: 32] = value & ~pulse_model[word*32 +: 32];   // Rising bits only
      pulse_model[word*32 +: 32] = value;
      for (int b = 0; b < pulse_width; b++)
         cnt[b] = 0;
      apb_write(addr_h2c_pulse + 8'(word*4), value, slverr);
      repeat (8)
      begin
         @(negedge axi_aclk);
         for (int b = 0; b < pulse_width; b++)
            if (h2c_pulse_out[b])
               cnt[b]++;
      end
      for (int b = 0; b < pulse_width; b++)
      begin
         seen_once[b] = (cnt[b] == 1);
         seen_more[b] = (cnt[b] > 1);
      end
      for (int w = 0; w < 2; w++)
      begin
         check_value($sformatf("%s word %0d", name, w), expected[w*32 +: 32],
                     seen_once[w*32 +: 32]);
         check_value($sformatf("%s word %0d long", name, w), 32'd0, seen_more[w*32 +: 32]);
      end
      apb_read(addr_h2c_pulse + 8'(word*4), rd, slverr);
      check_value({name, " read back"}, value, rd);
      finish_test(name);
   endtask

   task wait_irq(input logic level, input string name);
      int n;
      n = 0;
      @(negedge axi_aclk);
      while (irq_out !== level && n < timeout_cycles)
      begin
         @(negedge axi_aclk);
         n++;
      end
      if (irq_out !== level)
      begin
         errors++;
         $display("Timeout in %s, irq_out never reached %0b", name, level);
      end
   endtask

   task hold_irq(input logic level, input int cycles, input string name);
      repeat (cycles)
      begin
         @(negedge axi_aclk);
         check_value(name, {31'd0, level}, {31'd0, irq_out});
      end
   endtask

   task pulse_ack();
      @(posedge axi_aclk);
      irq_ack <= 1'b1;
      @(posedge axi_aclk);
      irq_ack <= 1'b0;
   endtask

   task read_user_status(input string name);
      for (int w = 0; w < 2; w++)
      begin
         apb_read(addr_c2h_status + 8'(w*4), rd, err);
         check_value($sformatf("%s level %0d", name, w), level_model[w*32 +: 32], rd);
         apb_read(addr_toggle_status + 8'(w*4), rd, err);
         check_value($sformatf("%s toggle %0d", name, w), toggle_model[w*32 +: 32], rd);
      end
      finish_test(name);
   endtask

   initial
   begin
      psel        <= 1'b0;
      penable     <= 1'b0;
      pwrite      <= 1'b0;
      paddr       <= '0;
      pwdata      <= '0;
      irq_ack     <= 1'b0;
      c2h_intr_in <= '0;
      c2h_gpio_in <= '0;
      axi_aresetn <= 1'b0;
      errors = 0;
      tests = 0;
      failed_tests = 0;
      errors_at_start = 0;
      pulse_model = '0;
      repeat (5) @(posedge axi_aclk);
      axi_aresetn <= 1'b1;

      @(negedge axi_aclk);
      check_value("irq_out after reset", 32'd0, {31'd0, irq_out});
      for (int w = 0; w < 4; w++)
         check_value("h2c_intr_out after reset", 32'd0, h2c_intr_out[w*32 +: 32]);
      for (int w = 0; w < 2; w++)
         check_value("h2c_pulse_out after reset", 32'd0, h2c_pulse_out[w*32 +: 32]);
      for (int a = 0; a < 32'h78; a += 4)
      begin
         apb_read(8'(a), rd, err);
         check_value($sformatf("reset read %h", a), 32'd0, rd);
      end
      finish_test("reset values");

      fill_table();
      for (int i = 0; i < tbl_count; i++)
      begin
         apb_write(tbl_addr[i], tbl_wdata[i], err);
         check_value({tbl_name[i], " write pslverr"}, {31'd0, tbl_err[i]}, {31'd0, err});
         apb_read(tbl_addr[i], rd, err);
         check_value(tbl_name[i], tbl_exp[i], rd);
         check_value({tbl_name[i], " read pslverr"}, {31'd0, tbl_err[i]}, {31'd0, err});
         finish_test(tbl_name[i]);
      end
      @(negedge axi_aclk);
      for (int w = 0; w < 4; w++)
         check_value("h2c_intr_out", intr_model[w*32 +: 32], h2c_intr_out[w*32 +: 32]);
      for (int w = 0; w < 8; w++)
         check_value("h2c_gpio_out", gpio_model[w*32 +: 32], h2c_gpio_out[w*32 +: 32]);
      finish_test("host outputs");
      apb_write(addr_toggle_enable, 32'd0, err);          // Keep irq quiet for now
      apb_write(addr_toggle_enable + 8'd4, 32'd0, err);

      pat = lcg_next();
      pulse_step("pulse first write", 0, pat);
      pulse_step("pulse same value", 0, pat);
      pulse_step("pulse new value", 0, lcg_next());
      pulse_step("pulse upper word", 1, lcg_next());

      level_model = '0;
      toggle_model = '0;
      for (int k = 0; k < 3; k++)
      begin
         next_in = {lcg_next(), lcg_next()};
         toggle_model = toggle_model | (next_in ^ level_model);
         level_model = next_in;
         @(posedge axi_aclk);
         c2h_intr_in <= next_in;
         repeat (2) @(posedge axi_aclk);
         read_user_status($sformatf("user interrupt sample %0d", k));
      end
      pat = lcg_next();
      apb_write(addr_toggle_clear, pat, err);
      toggle_model[31:0] = toggle_model[31:0] & ~pat;
      read_user_status("toggle partial clear");
      apb_write(addr_toggle_clear, 32'hffff_ffff, err);
      apb_write(addr_toggle_clear + 8'd4, 32'hffff_ffff, err);
      toggle_model = '0;
      read_user_status("toggle full clear");

      for (int w = 0; w < 8; w++)
         gpio_model[w*32 +: 32] = lcg_next();
      @(posedge axi_aclk);
      c2h_gpio_in <= gpio_model;
      repeat (2) @(posedge axi_aclk);
      for (int w = 0; w < 8; w++)
      begin
         apb_read(addr_c2h_gpio + 8'(w*4), rd, err);
         check_value($sformatf("c2h_gpio word %0d", w), gpio_model[w*32 +: 32], rd);
      end
      finish_test("user gpio");

      // Full handshake on line 5
      apb_write(addr_toggle_enable, 32'h20, err);
      @(posedge axi_aclk);
      c2h_intr_in <= c2h_intr_in ^ 64'h20;
      wait_irq(1'b1, "irq request");
      pulse_ack();
      hold_irq(1'b1, 4, "irq held after ack");
      apb_write(addr_toggle_clear, 32'h20, err);
      wait_irq(1'b0, "irq release");
      pulse_ack();
      finish_test("irq handshake");
      @(posedge axi_aclk);
      c2h_intr_in <= c2h_intr_in ^ 64'h40;                // Line 6 is not enabled
      hold_irq(1'b0, 8, "irq on disabled line");
      finish_test("disabled line");

      // Second ack must have brought the FSM back to idle
      @(posedge axi_aclk);
      c2h_intr_in <= c2h_intr_in ^ 64'h20;
      wait_irq(1'b1, "irq after second ack");
      finish_test("irq rearmed");

      $display("Tests: %0d  failed: %0d  mismatches: %0d", tests, failed_tests, errors);
      if (errors == 0)
         $display("Everything OK");
      else
         $display("Something failed");
      $finish;
   end

endmodule

/* project.f */
source/intr_pkg.sv
source/apb_reg_file.sv
source/c2h_input_capture.sv
source/irq_controller.sv
source/h2c_signal_gen.sv
source/intr_handler_top.sv
verification/intr_handler_assert.sv
verification/tb_intr_handler.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the interrupt bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert -f project.f --top-module tb_intr_handler -o sim_tb
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/sim_tb > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "Something failed" "$log"; then
   exit 1
fi
exit 0
